// ==== hw/ula.sv ====
// ****************************************
// ALU top with two stage pipeline
// Unit select, normalization, credit flow
// ****************************************

`timescale 1ns/1ps

module ula (
	input  logic              clk,
	input  logic              rst_n,
	input  ula_pkg::ula_req_t req,
	input  logic              req_valid,
	output logic              req_ready,
	output ula_pkg::ula_res_t res,
	output logic              res_valid,
	input  logic              credit_return
);
	import ula_pkg::*;

	logic              accept;
	logic              is_float;
	logic [NUBITS-1:0] int_data;
	logic [NUBITS-1:0] flt_data;
	logic [NUBITS-1:0] norm_data;
	logic              s1_valid;
	ula_op_t           s1_op;
	logic [NUBITS-1:0] s1_data;

	assign accept   = req_valid && req_ready;
	assign is_float = req.op inside {F_ADD, F_MLT, F_SGN, F_NEG, F_ABS, F_PST, F_LES, F_GRE};

	ula_credit u_credit (
		.clk           (clk),
		.rst_n         (rst_n),
		.accept        (accept),
		.credit_return (credit_return),
		.req_ready     (req_ready)
	);

	ula_int   u_int   (.req(req), .data(int_data));
	ula_float u_float (.req(req), .data(flt_data));

	// ****************************************
	// Stage 1 unit result
	// ****************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s1_op   <= req.op;                          // Kept for normalization
			s1_data <= is_float ? flt_data : int_data;
		end
	end

	ula_norm u_norm (.op(s1_op), .data_in(s1_data), .data(norm_data));

	// ****************************************
	// Stage 2 output register
	// ****************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= s1_valid;   // Never stalls since a credit holds the slot
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			res.data <= norm_data;
		end
	end

endmodule

// ==== hw/ula_credit.sv ====
// ****************************************
// Credit counter for result slots
// ****************************************

`timescale 1ns/1ps

module ula_credit (
	input  logic clk,
	input  logic rst_n,
	input  logic accept,
	input  logic credit_return,
	output logic req_ready
);
	import ula_pkg::*;

	logic [CRED_W-1:0] count;   // Free result slots

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= CRED_W'(RESULT_CREDITS);   // Consumer starts empty
		end else begin
			case ({accept, credit_return})
				2'b10:   count <= count - 1'b1;
				2'b01:   count <= count + 1'b1;
				default: count <= count;        // Both or neither
			endcase
		end
	end

	assign req_ready = (count != '0);

	// Consumer never returns more than it got
	a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
		count <= CRED_W'(RESULT_CREDITS));

	// Top must gate accept with req_ready
	a_no_accept_empty: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (count != '0));

endmodule

// ==== hw/ula_float.sv ====
// ****************************************
// Float exponent alignment
// Float add, multiply, sign ops, compares
// ****************************************

`timescale 1ns/1ps

module ula_float (
	input  ula_pkg::ula_req_t          req,
	output logic [ula_pkg::NUBITS-1:0] data
);
	import ula_pkg::*;

	fp_word_t f1;
	fp_word_t f2;

	assign f1 = req.in1;
	assign f2 = req.in2;

	// ****************************************
	// Exponent alignment
	// ****************************************

	logic signed [NBEXPO:0]   e_diff;   // e1 - e2, one guard bit
	logic                     e1_less;
	logic        [NBEXPO:0]   sh1;
	logic        [NBEXPO:0]   sh2;
	logic signed [NBEXPO-1:0] e_al;     // Common exponent
	logic        [NBMANT-1:0] m1_al;
	logic        [NBMANT-1:0] m2_al;
	logic signed [NBMANT:0]   sm1;      // Signed mantissas
	logic signed [NBMANT:0]   sm2;

	assign e_diff  = (NBEXPO+1)'(f1.exp) - (NBEXPO+1)'(f2.exp);
	assign e1_less = e_diff[NBEXPO];
	assign sh1     = e1_less ? -e_diff : '0;     // Smaller exponent side shifts
	assign sh2     = e1_less ? '0 : e_diff;
	assign e_al    = e1_less ? f2.exp : f1.exp;  // Larger exponent kept

	assign m1_al = f1.man >> sh1;
	assign m2_al = f2.man >> sh2;
	assign sm1   = f1.sign ? -{1'b0, m1_al} : {1'b0, m1_al};
	assign sm2   = f2.sign ? -{1'b0, m2_al} : {1'b0, m2_al};

	// ****************************************
	// F_ADD
	// ****************************************

	logic signed [NBMANT+1:0] sum;
	logic        [NBMANT+1:0] sum_mag;
	fp_word_t                 f_add;

	assign sum     = (NBMANT+2)'(sm1) + (NBMANT+2)'(sm2);
	assign sum_mag = sum[NBMANT+1] ? -sum : sum;

	// Drop one bit of the sum, exponent up to match
	assign f_add.sign = sum[NBMANT+1];
	assign f_add.exp  = e_al + NBEXPO'(1);
	assign f_add.man  = sum_mag[NBMANT:1];

	// ****************************************
	// F_MLT
	// ****************************************

	logic        [2*NBMANT-1:0] prod;
	logic signed [NBEXPO:0]     e_prod;
	logic                       unf;
	fp_word_t                   f_mlt;

	assign prod   = f1.man * f2.man;
	assign e_prod = (NBEXPO+1)'(f1.exp) + (NBEXPO+1)'(f2.exp) + (NBEXPO+1)'(NBMANT);
	assign unf    = (e_prod[NBEXPO:NBEXPO-1] == 2'b10);  // Below EXP_MIN

	assign f_mlt.sign = f1.sign ^ f2.sign;
	assign f_mlt.exp  = e_prod[NBEXPO-1:0];
	assign f_mlt.man  = unf ? '0 : prod[2*NBMANT-1:NBMANT];  // Upper half

	// Output select, unary ops work on in2
	always_comb begin
		case (req.op)
			F_ADD: data = f_add;
			F_MLT: data = f_mlt;
			F_SGN: data = {f1.sign, f2.exp, f2.man};
			F_NEG: data = {~f2.sign, f2.exp, f2.man};
			F_ABS: data = {1'b0, f2.exp, f2.man};
			F_PST: data = f2.sign ? {1'b0, EXP_MIN, {NBMANT{1'b0}}} : req.in2;
			F_LES: data = NUBITS'(sm1 < sm2);
			F_GRE: data = NUBITS'(sm1 > sm2);
			default: data = '0;  // Integer codes
		endcase
	end

endmodule

// ==== hw/ula_int.sv ====
// ****************************************
// Integer, bitwise and conditional ops
// Compares and shifts, NOP and LOD
// ****************************************

`timescale 1ns/1ps

module ula_int (
	input  ula_pkg::ula_req_t          req,
	output logic [ula_pkg::NUBITS-1:0] data
);
	import ula_pkg::*;

	logic signed [NUBITS-1:0] a;   // Memory operand
	logic signed [NUBITS-1:0] b;   // Accumulator operand
	logic                     a_nz;
	logic                     b_nz;

	assign a    = req.in1;
	assign b    = req.in2;
	assign a_nz = (a != '0);
	assign b_nz = (b != '0);

	// ****************************************
	// Operation select
	// ****************************************

	always_comb begin
		case (req.op)
			NOP: data = b;
			LOD: data = a;

			// Arithmetic
			ADD: data = a + b;
			MLT: data = a * b;                                 // Low word of product
			SGN: data = (a[NUBITS-1] == b[NUBITS-1]) ? b : -b; // Sign of in1 on in2
			NEG: data = -b;
			ABS: data = b[NUBITS-1] ? -b : b;
			PST: data = b[NUBITS-1] ? '0 : b;                  // Clamp negatives

			// Bitwise
			AND: data = a & b;
			ORR: data = a | b;
			XOR: data = a ^ b;
			INV: data = ~b;

			// Conditionals, result in bit 0
			LAN: data = NUBITS'(a_nz && b_nz);
			LOR: data = NUBITS'(a_nz || b_nz);
			LIN: data = NUBITS'(!b_nz);

			// Compares on raw words
			LES: data = NUBITS'(req.in1 < req.in2);  // Unsigned
			GRE: data = NUBITS'(req.in1 > req.in2);
			EQU: data = NUBITS'(req.in1 == req.in2);

			// Shift amount taken from in2
			SHL: data = req.in1 << req.in2;
			SHR: data = req.in1 >> req.in2;
			SRS: data = a >>> req.in2;               // Sign fill

			default: data = '0;                      // Float codes
		endcase
	end

endmodule

// ==== hw/ula_norm.sv ====
// ****************************************
// Float normalization for F_ADD and F_MLT
// ****************************************

`timescale 1ns/1ps

module ula_norm (
	input  ula_pkg::ula_op_t           op,
	input  logic [ula_pkg::NUBITS-1:0] data_in,
	output logic [ula_pkg::NUBITS-1:0] data
);
	import ula_pkg::*;

	fp_word_t             f_in;
	fp_word_t             f_out;
	logic [NORM_SH_W-1:0] lz;          // Leading zeros of mantissa
	logic                 need_norm;

	assign f_in      = data_in;
	assign need_norm = (op == F_ADD) || (op == F_MLT);

	// Upward scan so the highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < NBMANT; i++) begin
			if (f_in.man[i]) begin
				lz = NORM_SH_W'(NBMANT - 1 - i);
			end
		end
	end

	always_comb begin
		f_out.sign = f_in.sign;
		f_out.man  = f_in.man << lz;   // Top bit ends up set
		if (f_in.man == '0) begin
			f_out.exp = EXP_MIN;       // Float zero
		end else begin
			f_out.exp = f_in.exp - NBEXPO'(lz);
		end

		// Normalized or the canonical zero
		if (need_norm && !$isunknown(data_in)) begin
			assert (f_out.man[NBMANT-1] || (f_out.man == '0 && f_out.exp == EXP_MIN))
				else $error("norm output %h is not normalized at %0t", f_out, $time);
		end
	end

	assign data = need_norm ? f_out : data_in;  // Other ops untouched

endmodule

// ==== hw/ula_pkg.sv ====
// ****************************************
// Shared widths, operation codes and credit count
// Request, result and float word structs
// ****************************************

package ula_pkg;

	// ****************************************
	// Widths
	// ****************************************

	localparam int NUBITS = 32;                     // Data word
	localparam int NBMANT = 23;                     // Mantissa, no hidden bit
	localparam int NBEXPO = 8;                      // Two's complement exponent
	localparam int NORM_SH_W = $clog2(NBMANT);      // Normalization shift count

	// Most negative exponent, used for float zero
	localparam logic signed [NBEXPO-1:0] EXP_MIN = {1'b1, {(NBEXPO-1){1'b0}}};

	// Result slots on the consumer side
	localparam int RESULT_CREDITS = 4;
	localparam int CRED_W = $clog2(RESULT_CREDITS + 1);

	// ****************************************
	// Operation codes
	// ****************************************

	typedef enum logic [5:0] {
		NOP   = 6'd0,  LOD   = 6'd1,               // Pass through
		ADD   = 6'd2,  F_ADD = 6'd3,
		MLT   = 6'd4,  F_MLT = 6'd5,
		SGN   = 6'd9,  F_SGN = 6'd10,
		NEG   = 6'd11, F_NEG = 6'd13,
		ABS   = 6'd15, F_ABS = 6'd17,
		PST   = 6'd19, F_PST = 6'd21,
		AND   = 6'd29, ORR   = 6'd30, XOR = 6'd31,  // Bitwise
		INV   = 6'd32,
		LAN   = 6'd34, LOR   = 6'd35, LIN = 6'd36,  // Conditionals
		LES   = 6'd38, F_LES = 6'd39,               // Compares
		GRE   = 6'd40, F_GRE = 6'd41,
		EQU   = 6'd42,
		SHL   = 6'd43, SHR   = 6'd44, SRS = 6'd45   // Shifts
	} ula_op_t;

	// ****************************************
	// Bus structs
	// ****************************************

	typedef struct packed {
		ula_op_t           op;
		logic [NUBITS-1:0] in1;   // From memory
		logic [NUBITS-1:0] in2;   // From accumulator
	} ula_req_t;

	// Float view of a data word
	typedef struct packed {
		logic                     sign;
		logic signed [NBEXPO-1:0] exp;
		logic        [NBMANT-1:0] man;
	} fp_word_t;

	typedef struct packed {
		logic [NUBITS-1:0] data;
	} ula_res_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ula testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module ula_tb -f sim.f -o ula_tb_sim

./obj_dir/ula_tb_sim | tee "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
	exit 0
else
	exit 1
fi

// ==== sim.f ====
hw/ula_pkg.sv
hw/ula_int.sv
hw/ula_float.sv
hw/ula_norm.sv
hw/ula_credit.sv
hw/ula.sv
sim/ula_tb.sv

// ==== sim/ula_tb.sv ====
// ****************************************
// Testbench for the ula pipeline
// Random requests, credit consumer, checks
// ****************************************

`timescale 1ns/1ps

module ula_tb;
	import ula_pkg::*;

	localparam int NUM_REQ    = 400;
	localparam int MAX_CYCLES = 2000;  // About 1.5 cycles per request at the credit limit plus idle
	localparam ula_op_t OPS [29] = '{NOP, LOD, ADD, F_ADD, MLT, F_MLT, SGN, F_SGN, NEG, F_NEG,
		ABS, F_ABS, PST, F_PST, AND, ORR, XOR, INV, LAN, LOR, LIN, LES, F_LES, GRE, F_GRE,
		EQU, SHL, SHR, SRS};

	typedef struct packed {
		ula_req_t    req;
		logic [31:0] cyc;   // Accept cycle
	} pend_t;

	logic     clk;
	logic     rst_n;
	ula_req_t req;
	logic     req_valid;
	logic     req_ready;
	ula_res_t res;
	logic     res_valid;
	logic     credit_return;

	integer      seed = 30;
	int unsigned cyc = 0;
	int unsigned n_gen = 0;
	int unsigned n_acc = 0;
	int          outstanding = 0;  // Accepted with credit not yet back
	int          data_errs = 0;
	int          flow_errs = 0;
	int          lat_miss = 0;
	int          lat_extra = 0;
	logic        accepted;
	logic        all_done = 1'b0;
	pend_t       p;
	pend_t       pend_q[$];        // Results still due
	int unsigned due_q[$];         // Cycles when a credit goes back

	ula DUT (
		.clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid), .req_ready(req_ready),
		.res(res), .res_valid(res_valid), .credit_return(credit_return)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Signed mantissa of a float word
	function automatic logic signed [NBMANT+1:0] signed_mant(fp_word_t f);
		logic signed [NBMANT+1:0] m;
		m = $signed({2'b00, f.man});
		return f.sign ? -m : m;
	endfunction

	function automatic ula_req_t make_req();
		ula_req_t r;
		fp_word_t f1;
		fp_word_t f2;
		r.op  = OPS[$unsigned($random(seed)) % 29];
		r.in1 = $random(seed);
		r.in2 = $random(seed);
		if (($random(seed) & 3) == 0) r.in1 = '0;     // Zero operands for conditionals
		if (($random(seed) & 3) == 0) r.in2 = '0;
		if (r.op inside {SHL, SHR, SRS}) r.in2 = r.in2 & 32'h3f;  // Some past 31
		if (r.op inside {F_ADD, F_MLT, F_LES, F_GRE} && $random(seed) & 1) begin
			f1     = r.in1;
			f2     = r.in2;
			f2.exp = f1.exp;                          // Equal exponents
			r.in2  = f2;
		end
		return r;
	endfunction

	// Exact result of every op that has one
	function automatic logic [NUBITS-1:0] expected_exact(ula_req_t r);
		logic [NUBITS-1:0]        a;
		logic [NUBITS-1:0]        b;
		logic signed [NUBITS-1:0] sra;
		a = r.in1;
		b = r.in2;
		case (r.op)
			NOP:     return b;
			LOD:     return a;
			ADD:     return a + b;
			MLT:     return a * b;
			SGN:     return (a[31] ^ b[31]) ? ~b + 1 : b;
			NEG:     return ~b + 1;
			ABS:     return b[31] ? ~b + 1 : b;
			PST:     return b[31] ? '0 : b;
			AND:     return a & b;
			ORR:     return a | b;
			XOR:     return a ^ b;
			INV:     return ~b;
			LAN:     return {31'b0, (a != 0) && (b != 0)};
			LOR:     return {31'b0, (a != 0) || (b != 0)};
			LIN:     return {31'b0, b == 0};
			LES:     return {31'b0, a < b};
			GRE:     return {31'b0, a > b};
			EQU:     return {31'b0, a == b};
			SHL:     return (b > 31) ? '0 : a << b[4:0];
			SHR:     return (b > 31) ? '0 : a >> b[4:0];
			SRS: begin
				sra = $signed(a) >>> b[4:0];           // Sign fill
				return (b > 31) ? {32{a[31]}} : sra;
			end
			F_SGN:   return {a[31], b[30:0]};
			F_NEG:   return {~b[31], b[30:0]};
			F_ABS:   return {1'b0, b[30:0]};
			F_PST:   return b[31] ? {1'b0, EXP_MIN, {NBMANT{1'b0}}} : b;
			default: return '0;
		endcase
	endfunction

	task automatic check_result(pend_t pe, logic [NUBITS-1:0] got);
		fp_word_t                 f1;
		fp_word_t                 f2;
		fp_word_t                 g;
		logic signed [NBMANT+1:0] msum;
		logic                     want_sign;
		logic [NUBITS-1:0]        want;
		f1 = pe.req.in1;
		f2 = pe.req.in2;
		g  = got;
		if (pe.req.op inside {F_ADD, F_MLT}) begin
			assert (g.man[NBMANT-1] || (g.man == '0 && g.exp == EXP_MIN)) else begin
				data_errs++;
				$display("%s result %h is not normalized at %0t", pe.req.op.name(), got, $time);
			end
			if (f1.exp == f2.exp) begin
				msum      = signed_mant(f1) + signed_mant(f2);
				want_sign = (pe.req.op == F_ADD) ? (msum < 0) : (f1.sign ^ f2.sign);
				assert (g.sign == want_sign) else begin
					data_errs++;
					$display("mismatch %0t res.data.sign expected %b actual %b",
						$time, want_sign, g.sign);
				end
			end
		end else if (pe.req.op inside {F_LES, F_GRE}) begin
			if (f1.exp == f2.exp) begin
				want = (pe.req.op == F_LES) ? {31'b0, signed_mant(f1) < signed_mant(f2)}
					: {31'b0, signed_mant(f1) > signed_mant(f2)};
				assert (got == want) else begin
					data_errs++;
					$display("mismatch %0t res.data expected %h actual %h", $time, want, got);
				end
			end
		end else begin
			want = expected_exact(pe.req);
			assert (got == want) else begin
				data_errs++;
				$display("mismatch %0t res.data expected %h actual %h", $time, want, got);
			end
		end
	endtask

	// ****************************************
	// Stimulus, consumer and flow checks
	// ****************************************

	always @(posedge clk) begin
		if (rst_n) begin
			accepted = req_valid && req_ready;
			assert (req_ready == (outstanding < RESULT_CREDITS)) else begin
				flow_errs++;
				$display("mismatch %0t req_ready expected %b actual %b",
					$time, outstanding < RESULT_CREDITS, req_ready);
			end
			assert (outstanding <= RESULT_CREDITS) else begin
				flow_errs++;
				$display("more requests in flight than credits at %0t", $time);
			end
			if (n_acc == 0) begin
				assert (!res_valid && req_ready) else begin
					flow_errs++;
					$display("outputs not idle before the first accept at %0t", $time);
				end
			end
			if (res_valid) begin
				if (pend_q.size() == 0) begin
					flow_errs++;
					$display("result appeared with no request pending at %0t", $time);
				end else begin
					p = pend_q.pop_front();
					assert (cyc == p.cyc + 2) else begin
						flow_errs++;
						$display("mismatch %0t result cycle expected %0d actual %0d",
							$time, p.cyc + 2, cyc);
					end
					check_result(p, res.data);
				end
				due_q.push_back(cyc + ($unsigned($random(seed)) % 4));  // Slot freed later
			end
			if (accepted) begin
				pend_q.push_back('{req, cyc});
				n_acc++;
			end
			outstanding = outstanding + int'(accepted) - int'(credit_return);
			if (due_q.size() != 0 && due_q[0] <= cyc) begin
				void'(due_q.pop_front());
				credit_return <= 1'b1;
			end else begin
				credit_return <= 1'b0;
			end
			if (!req_valid || req_ready) begin     // Hold a stalled request
				if (n_gen < NUM_REQ && ($random(seed) & 3) != 0) begin
					req       <= make_req();
					req_valid <= 1'b1;
					n_gen++;
				end else begin
					req_valid <= 1'b0;
				end
			end
			all_done = (n_acc == NUM_REQ) && (pend_q.size() == 0) && (due_q.size() == 0)
				&& (outstanding == 0);
		end
		cyc++;
	end

	a_res_follows: assert property (@(posedge clk) disable iff (!rst_n)
		(req_valid && req_ready) |-> ##2 res_valid)
		else begin
			lat_miss++;
			$display("result missing two cycles after an accept at %0t", $time);
		end

	a_res_origin: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> $past(req_valid && req_ready, 2))
		else begin
			lat_extra++;
			$display("result without an accept two cycles before at %0t", $time);
		end

	initial begin : watchdog
		while (cyc < MAX_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles with %0d of %0d requests accepted",
			cyc, n_acc, NUM_REQ);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst_n         = 1'b0;
		req           = '0;
		req_valid     = 1'b0;
		credit_return = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		while (!all_done) @(posedge clk);
		repeat (2) @(posedge clk);
		$display("requests %0d, errors data %0d flow %0d latency %0d extra %0d",
			n_acc, data_errs, flow_errs, lat_miss, lat_extra);
		if (data_errs + flow_errs + lat_miss + lat_extra == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
